// ==== fetch_top.f ====
hdl/fetch_pkg.sv
hdl/pc_gen.sv
hdl/branch_predecode.sv
hdl/fetch_queue.sv
hdl/fetch_top.sv
sim/fetch_props.sv
sim/tb_fetch_top.sv

// ==== Makefile ====
SIM = obj_dir/Vtb_fetch_top

.PHONY: all run clean

all: run

$(SIM): fetch_top.f $(wildcard hdl/*.sv sim/*.sv)
	verilator --binary --timing --assert -f fetch_top.f --top-module tb_fetch_top -o Vtb_fetch_top

run: $(SIM)
	$(SIM) > sim.log; cat sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/tb_fetch_top.sv ====
// Fetch front end testbench

`timescale 1ns/1ps

module tb_fetch_top import fetch_pkg::*; ();

    localparam int NROWS      = 7;
    localparam int READY_LOW  = 0;
    localparam int READY_HIGH = 1;
    localparam int READY_RAND = 2;
    localparam logic [XLEN-1:0] BOOT_ADDR = 32'h0000_1000;

    logic            clk_i = 1'b0;
    logic            rst_ni;
    logic [XLEN-1:0] boot_addr_i;
    logic            ex_valid_i;
    logic [XLEN-1:0] trap_vector_base_i;
    logic            eret_i;
    logic [XLEN-1:0] epc_i;
    logic            resolve_valid_i;
    logic            resolve_mispredict_i;
    logic [XLEN-1:0] resolve_target_i;
    logic            fetch_req_o;
    logic [XLEN-1:0] fetch_addr_o;
    logic            fetch_valid_i;
    logic [XLEN-1:0] fetch_data_i;
    logic            fetch_valid_o;
    logic [XLEN-1:0] fetch_pc_o;
    logic [XLEN-1:0] fetch_instr_o;
    logic            fetch_taken_o;
    logic            fetch_ready_i;

    // ----------------------------------------------------------------------
    // program table, address / word / taken / next delivered pc
    // ----------------------------------------------------------------------
    logic [XLEN-1:0] tbl_addr  [NROWS] = '{32'h1000, 32'h1004, 32'h1008, 32'h1028,
                                          32'h102c, 32'h1030, 32'h1034};
    logic [XLEN-1:0] tbl_instr [NROWS] = '{32'h0010_0093, 32'h0020_0113, 32'h0200_006f,
                                          32'h0000_0863, 32'h0000_8067, 32'h0030_0193,
                                          32'hfe00_1ae3};
    logic            tbl_taken [NROWS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1};
    logic [XLEN-1:0] tbl_next  [NROWS] = '{32'h1004, 32'h1008, 32'h1028, 32'h102c,
                                          32'h1030, 32'h1034, 32'h1028};

    // sparse instruction memory
    logic [XLEN-1:0] imem [logic [XLEN-1:0]];

    logic            req_pending;
    logic [XLEN-1:0] addr_pending;
    logic [XLEN-1:0] exp_pc;
    logic [31:0]     rng;
    int              errors;
    int              checks;
    int              delivered;
    bit              timed_out;

    fetch_top u_dut (.*);

    bind fetch_top fetch_props u_fetch_props (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .ex_valid_i           (ex_valid_i),
        .eret_i               (eret_i),
        .resolve_valid_i      (resolve_valid_i),
        .resolve_mispredict_i (resolve_mispredict_i),
        .fetch_req_o          (fetch_req_o),
        .fetch_valid_o        (fetch_valid_o),
        .fetch_pc_o           (fetch_pc_o),
        .fetch_ready_i        (fetch_ready_i)
    );

    always #50 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // OP-IMM word mixing every address bit, never a control-flow opcode
    function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] a);
        return {a[31:7] ^ a[24:0], 7'b001_0011};
    endfunction

    function automatic logic [XLEN-1:0] read_word(input logic [XLEN-1:0] a);
        if (imem.exists(a)) begin
            return imem[a];
        end
        return fill_word(a);
    endfunction

    // ----------------------------------------------------------------------
    // reference model and checks
    // ----------------------------------------------------------------------
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // plain words fall through, table words carry their own outcome
    task automatic check_entry();
        logic            exp_taken;
        logic [XLEN-1:0] next_pc;
        exp_taken = 1'b0;
        next_pc   = exp_pc + 32'd4;
        for (int i = 0; i < NROWS; i++) begin
            if (tbl_addr[i] == exp_pc) begin
                exp_taken = tbl_taken[i];
                next_pc   = tbl_next[i];
            end
        end
        check_value("pc", fetch_pc_o, exp_pc);
        check_value("instr", fetch_instr_o, read_word(exp_pc));
        check_value("taken", 32'(fetch_taken_o), 32'(exp_taken));
        exp_pc = next_pc;
        delivered++;
    endtask

    // one cycle: memory answer, ready, redirect pulses, then sample the request
    task automatic step(input int ready_sel, input logic ex_v, input logic eret_v,
                        input logic misp_v);
        @(negedge clk_i);
        fetch_valid_i = req_pending;
        fetch_data_i  = req_pending ? read_word(addr_pending) : '0;
        if (ready_sel == READY_RAND) begin
            rng           = xorshift(rng);
            fetch_ready_i = (rng[3:2] != 2'b00);
        end else begin
            fetch_ready_i = (ready_sel == READY_HIGH);
        end
        ex_valid_i           = ex_v;
        eret_i               = eret_v;
        resolve_valid_i      = misp_v;
        resolve_mispredict_i = misp_v;
        if (fetch_valid_o && fetch_ready_i) begin
            check_entry();
        end
        #1;
        req_pending  = fetch_req_o;
        addr_pending = fetch_addr_o;
    endtask

    task automatic wait_entries(input int count, input int ready_sel, input int timeout);
        int target;
        int cycles;
        target = delivered + count;
        cycles = 0;
        while (delivered < target && cycles < timeout) begin
            step(ready_sel, 1'b0, 1'b0, 1'b0);
            cycles++;
        end
        if (delivered < target) begin
            $display("timeout: %0d of %0d entries delivered", delivered - target + count,
                     count);
            timed_out = 1'b1;
        end
    endtask

    // fill the queue, drain until requests resume, then pulse with a response in flight
    task automatic apply_redirect(input logic ex_v, input logic eret_v, input logic misp_v,
                                  input logic [XLEN-1:0] target);
        int cycles;
        for (int i = 0; i < 8; i++) begin
            step(READY_LOW, 1'b0, 1'b0, 1'b0);
        end
        // room comes back once enough entries have left
        cycles = 0;
        while (!req_pending && cycles < 20) begin
            step(READY_HIGH, 1'b0, 1'b0, 1'b0);
            cycles++;
        end
        if (!req_pending) begin
            $display("timeout: no memory request while draining the queue");
            timed_out = 1'b1;
        end else begin
            // queued entries and the arriving response both go away
            step(READY_LOW, ex_v, eret_v, misp_v);
            exp_pc = target;
            wait_entries(6, READY_RAND, 100);
        end
    endtask

    initial begin
        rst_ni               = 1'b0;
        boot_addr_i          = BOOT_ADDR;
        ex_valid_i           = 1'b0;
        trap_vector_base_i   = 32'h0000_3000;
        eret_i               = 1'b0;
        epc_i                = 32'h0000_2000;
        resolve_valid_i      = 1'b0;
        resolve_mispredict_i = 1'b0;
        resolve_target_i     = 32'h0000_4000;
        fetch_valid_i        = 1'b0;
        fetch_data_i         = '0;
        fetch_ready_i        = 1'b0;
        req_pending          = 1'b0;
        addr_pending         = '0;
        rng                  = 32'h8ce40505;
        errors               = 0;
        checks               = 0;
        delivered            = 0;
        timed_out            = 1'b0;
        exp_pc               = BOOT_ADDR;

        for (int i = 0; i < NROWS; i++) begin
            imem[tbl_addr[i]] = tbl_instr[i];
        end

        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        #1;
        req_pending  = fetch_req_o;
        addr_pending = fetch_addr_o;

        // ------------------------------------------------------------------
        // straight line, jumps and branches, then back-pressure
        // ------------------------------------------------------------------
        wait_entries(10, READY_HIGH, 100);
        if (!timed_out) begin
            wait_entries(60, READY_RAND, 600);
        end

        // redirects, trap beats eret when both pulse
        if (!timed_out) begin
            apply_redirect(1'b0, 1'b1, 1'b0, epc_i);
        end
        if (!timed_out) begin
            apply_redirect(1'b1, 1'b0, 1'b0, trap_vector_base_i);
        end
        if (!timed_out) begin
            apply_redirect(1'b0, 1'b0, 1'b1, resolve_target_i);
        end
        if (!timed_out) begin
            trap_vector_base_i = 32'h0000_5000;
            epc_i              = 32'h0000_6000;
            apply_redirect(1'b1, 1'b1, 1'b0, 32'h0000_5000);
        end

        $display("checks: %0d, entries: %0d, errors: %0d", checks, delivered, errors);
        if (errors == 0 && !timed_out) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== sim/fetch_props.sv ====
// Fetch interface properties

`timescale 1ns/1ps

module fetch_props import fetch_pkg::*; (
    input logic            clk_i,
    input logic            rst_ni,
    input logic            ex_valid_i,
    input logic            eret_i,
    input logic            resolve_valid_i,
    input logic            resolve_mispredict_i,
    input logic            fetch_req_o,
    input logic            fetch_valid_o,
    input logic [XLEN-1:0] fetch_pc_o,
    input logic            fetch_ready_i
);

    logic redirect;

    // same redirect condition as the back end sees it
    assign redirect = ex_valid_i | eret_i | (resolve_valid_i & resolve_mispredict_i);

    // ----------------------------------------------------------------------
    // back-end handshake
    // ----------------------------------------------------------------------

    // a stalled entry stays put unless a redirect flushes it
    hold_while_stalled: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (fetch_valid_o && !fetch_ready_i && !redirect) |=>
        (fetch_valid_o && $stable(fetch_pc_o)))
        else $error("output entry changed while ready was low");

    // no memory request while redirecting
    no_req_on_redirect: assert property (@(posedge clk_i) disable iff (!rst_ni)
        redirect |-> !fetch_req_o)
        else $error("memory request issued in a redirect cycle");

    // nothing can be ready for the back end right out of reset
    idle_after_reset: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> !fetch_valid_o)
        else $error("output valid high right after reset release");

endmodule

// ==== hdl/fetch_top.sv ====
// Instruction fetch front end

`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic [XLEN-1:0] boot_addr_i,
    // back-end redirects
    input  logic            ex_valid_i,
    input  logic [XLEN-1:0] trap_vector_base_i,
    input  logic            eret_i,
    input  logic [XLEN-1:0] epc_i,
    input  logic            resolve_valid_i,
    input  logic            resolve_mispredict_i,
    input  logic [XLEN-1:0] resolve_target_i,
    // instruction memory
    output logic            fetch_req_o,
    output logic [XLEN-1:0] fetch_addr_o,
    input  logic            fetch_valid_i,
    input  logic [XLEN-1:0] fetch_data_i,
    // to the back end
    output logic            fetch_valid_o,
    output logic [XLEN-1:0] fetch_pc_o,
    output logic [XLEN-1:0] fetch_instr_o,
    output logic            fetch_taken_o,
    input  logic            fetch_ready_i
);

    logic [XLEN-1:0] rsp_pc;
    logic            predict_taken;
    logic [XLEN-1:0] predict_target;
    logic            push;
    logic            flush;
    logic            room;

    // ----------------------------------------------------------------------
    // PC generation and memory request
    // ----------------------------------------------------------------------
    pc_gen u_pc_gen (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .boot_addr_i          (boot_addr_i),
        .ex_valid_i           (ex_valid_i),
        .trap_vector_base_i   (trap_vector_base_i),
        .eret_i               (eret_i),
        .epc_i                (epc_i),
        .resolve_valid_i      (resolve_valid_i),
        .resolve_mispredict_i (resolve_mispredict_i),
        .resolve_target_i     (resolve_target_i),
        .room_i               (room),
        .fetch_valid_i        (fetch_valid_i),
        .predict_taken_i      (predict_taken),
        .predict_target_i     (predict_target),
        .fetch_req_o          (fetch_req_o),
        .fetch_addr_o         (fetch_addr_o),
        .rsp_pc_o             (rsp_pc),
        .push_o               (push),
        .flush_o              (flush)
    );

    // scan the returning word against its own PC
    branch_predecode u_branch_predecode (
        .pc_i             (rsp_pc),
        .instr_i          (fetch_data_i),
        .predict_taken_o  (predict_taken),
        .predict_target_o (predict_target)
    );

    // ----------------------------------------------------------------------
    // queue to the back end
    // ----------------------------------------------------------------------
    fetch_queue u_fetch_queue (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .push_i        (push),
        .pc_i          (rsp_pc),
        .instr_i       (fetch_data_i),
        .taken_i       (predict_taken),
        .flush_i       (flush),
        .room_o        (room),
        .fetch_valid_o (fetch_valid_o),
        .fetch_pc_o    (fetch_pc_o),
        .fetch_instr_o (fetch_instr_o),
        .fetch_taken_o (fetch_taken_o),
        .fetch_ready_i (fetch_ready_i)
    );

endmodule

// ==== hdl/fetch_queue.sv ====
// Fetch queue towards the back end

`timescale 1ns/1ps

module fetch_queue import fetch_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            push_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] instr_i,
    input  logic            taken_i,
    input  logic            flush_i,
    output logic            room_o,
    output logic            fetch_valid_o,
    output logic [XLEN-1:0] fetch_pc_o,
    output logic [XLEN-1:0] fetch_instr_o,
    output logic            fetch_taken_o,
    input  logic            fetch_ready_i
);

    // storage
    logic [XLEN-1:0]        pc_mem    [QUEUE_DEPTH];
    logic [XLEN-1:0]        instr_mem [QUEUE_DEPTH];
    logic                   taken_mem [QUEUE_DEPTH];

    logic [QUEUE_PTR_W-1:0] wr_ptr_q;
    logic [QUEUE_PTR_W-1:0] rd_ptr_q;
    logic [QUEUE_PTR_W-1:0] rd_ptr_d;
    logic [QUEUE_PTR_W:0]   count_q;
    logic [QUEUE_PTR_W:0]   count_d;
    logic [QUEUE_PTR_W:0]   count_left;
    logic                   valid_q;
    logic                   pop;
    logic                   head_is_new;

    // ----------------------------------------------------------------------
    // pointer and occupancy
    // ----------------------------------------------------------------------

    // output valid mirrors a non-empty queue
    assign pop = valid_q & fetch_ready_i;

    assign rd_ptr_d   = rd_ptr_q + QUEUE_PTR_W'(pop);
    assign count_left = count_q - (QUEUE_PTR_W + 1)'(pop);
    assign count_d    = count_left + (QUEUE_PTR_W + 1)'(push_i);

    // queue ran dry, so the pushed word becomes the head directly
    assign head_is_new = push_i && (count_left == '0);

    // one slot for the response in flight, one for the next request
    assign room_o = (count_q <= (QUEUE_PTR_W + 1)'(QUEUE_DEPTH - 2));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            valid_q  <= 1'b0;
        end else if (flush_i) begin
            // flush beats a push in the same cycle
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            valid_q  <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + QUEUE_PTR_W'(1);
            end
            rd_ptr_q <= rd_ptr_d;
            count_q  <= count_d;
            valid_q  <= (count_d != '0);
        end
    end

    // ----------------------------------------------------------------------
    // data path, registered head
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            pc_mem[wr_ptr_q]    <= pc_i;
            instr_mem[wr_ptr_q] <= instr_i;
            taken_mem[wr_ptr_q] <= taken_i;
        end
        // unchanged while stalled since rd_ptr holds and wr_ptr points elsewhere
        if (head_is_new) begin
            fetch_pc_o    <= pc_i;
            fetch_instr_o <= instr_i;
            fetch_taken_o <= taken_i;
        end else begin
            fetch_pc_o    <= pc_mem[rd_ptr_d];
            fetch_instr_o <= instr_mem[rd_ptr_d];
            fetch_taken_o <= taken_mem[rd_ptr_d];
        end
    end

    assign fetch_valid_o = valid_q;

endmodule

// ==== hdl/branch_predecode.sv ====
// Static branch predecoder

`timescale 1ns/1ps

module branch_predecode import fetch_pkg::*; (
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] instr_i,
    output logic            predict_taken_o,
    output logic [XLEN-1:0] predict_target_o
);

    instr_class_e    instr_class;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm;

    // ----------------------------------------------------------------------
    // opcode classification
    // ----------------------------------------------------------------------
    always_comb begin
        unique case (instr_i[6:0])
            OPC_BRANCH: instr_class = CLS_BRANCH;
            OPC_JAL:    instr_class = CLS_JAL;
            OPC_JALR:   instr_class = CLS_JALR;
            default:    instr_class = CLS_OTHER;
        endcase
    end

    // ----------------------------------------------------------------------
    // immediates
    // ----------------------------------------------------------------------

    // J-type, imm[20|10:1|11|19:12], bit 0 always zero
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    // B-type, imm[12|10:5] and imm[4:1|11]
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};

    // ----------------------------------------------------------------------
    // prediction
    // ----------------------------------------------------------------------
    always_comb begin
        imm             = '0;
        predict_taken_o = 1'b0;
        unique case (instr_class)
            // direct jumps are always taken
            CLS_JAL: begin
                imm             = imm_j;
                predict_taken_o = 1'b1;
            end
            // backward taken, forward not taken
            CLS_BRANCH: begin
                imm             = imm_b;
                predict_taken_o = imm_b[XLEN-1];
            end
            // no target without a BTB, fall through
            CLS_JALR: begin
                predict_taken_o = 1'b0;
            end
            default: begin
                predict_taken_o = 1'b0;
            end
        endcase
    end

    // PC-relative target
    assign predict_target_o = pc_i + imm;

endmodule

// ==== hdl/pc_gen.sv ====
// Fetch PC generation

`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic [XLEN-1:0] boot_addr_i,
    // redirects from the back end
    input  logic            ex_valid_i,
    input  logic [XLEN-1:0] trap_vector_base_i,
    input  logic            eret_i,
    input  logic [XLEN-1:0] epc_i,
    input  logic            resolve_valid_i,
    input  logic            resolve_mispredict_i,
    input  logic [XLEN-1:0] resolve_target_i,
    // queue and predecoder
    input  logic            room_i,
    input  logic            fetch_valid_i,
    input  logic            predict_taken_i,
    input  logic [XLEN-1:0] predict_target_i,
    // memory request and queue control
    output logic            fetch_req_o,
    output logic [XLEN-1:0] fetch_addr_o,
    output logic [XLEN-1:0] rsp_pc_o,
    output logic            push_o,
    output logic            flush_o
);

    // next PC and the one-shot boot load
    logic [XLEN-1:0] npc_d;
    logic [XLEN-1:0] npc_q;
    logic            npc_rst_load_q;

    // outstanding request, address and pending flag
    logic [XLEN-1:0] rsp_pc_q;
    logic            req_q;

    logic            mispredict;
    logic            redirect;
    logic            accept;
    logic [XLEN-1:0] base_pc;

    // ----------------------------------------------------------------------
    // redirect and response handling
    // ----------------------------------------------------------------------

    // a resolved branch only redirects when it was mispredicted
    assign mispredict = resolve_valid_i & resolve_mispredict_i;

    // any back-end redirect kills this cycle's request and response
    assign redirect = ex_valid_i | eret_i | mispredict;

    // response counts only if we actually asked for it last cycle
    assign accept = fetch_valid_i & req_q & ~redirect;

    assign push_o  = accept;
    assign flush_o = redirect;

    // ----------------------------------------------------------------------
    // fetch address
    // ----------------------------------------------------------------------

    // boot address wins in the first cycle out of reset
    assign base_pc = npc_rst_load_q ? boot_addr_i : npc_q;

    // a taken prediction steers this very request, no bubble
    assign fetch_addr_o = (accept && predict_taken_i) ? predict_target_i : base_pc;

    // request whenever the queue can take two more entries
    assign fetch_req_o = room_i & ~redirect;

    assign rsp_pc_o = rsp_pc_q;

    // ----------------------------------------------------------------------
    // next PC, fixed priority
    // ----------------------------------------------------------------------
    always_comb begin
        // hold the fetch address, keeps a prediction when no request goes out
        npc_d = fetch_addr_o;

        // sequential step after an issued request, word aligned
        if (fetch_req_o) begin
            npc_d = {fetch_addr_o[XLEN-1:2], 2'b00} + INSTR_ADVANCE;
        end

        // back-end redirects, highest priority first
        if (ex_valid_i) begin
            npc_d = trap_vector_base_i;
        end else if (eret_i) begin
            npc_d = epc_i;
        end else if (mispredict) begin
            npc_d = resolve_target_i;
        end
    end

    // control state
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            npc_rst_load_q <= 1'b1;
            npc_q          <= '0;
            req_q          <= 1'b0;
        end else begin
            npc_rst_load_q <= 1'b0;
            npc_q          <= npc_d;
            req_q          <= fetch_req_o;
        end
    end

    // address of the request now in flight
    always_ff @(posedge clk_i) begin
        if (fetch_req_o) begin
            rsp_pc_q <= fetch_addr_o;
        end
    end

endmodule

// ==== hdl/fetch_pkg.sv ====
// Instruction fetch shared definitions

package fetch_pkg;

    // ----------------------------------------------------------------------
    // widths and sizes
    // ----------------------------------------------------------------------

    // address and instruction width
    localparam int unsigned XLEN = 32;

    // number of fetch queue entries, a power of two so pointers wrap freely
    localparam int unsigned QUEUE_DEPTH = 4;

    // read and write pointer width
    localparam int unsigned QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

    // sequential step between uncompressed instructions
    localparam logic [XLEN-1:0] INSTR_ADVANCE = 32'd4;

    // ----------------------------------------------------------------------
    // major opcodes of interest to the predecoder
    // ----------------------------------------------------------------------

    // conditional branch, B-type immediate
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;

    // direct jump, J-type immediate
    localparam logic [6:0] OPC_JAL = 7'b110_1111;

    // indirect jump, target only known in the back end
    localparam logic [6:0] OPC_JALR = 7'b110_0111;

    // ----------------------------------------------------------------------
    // instruction classes
    // ----------------------------------------------------------------------

    // control-flow class of a fetched word
    typedef enum logic [1:0] {
        CLS_OTHER  = 2'd0,
        CLS_BRANCH = 2'd1,
        CLS_JAL    = 2'd2,
        CLS_JALR   = 2'd3
    } instr_class_e;

endpackage
